// File: dual_decode.f
+incdir+sim
rtl/rv_isa_pkg.sv
rtl/decode_pkg.sv
rtl/bundle_if.sv
rtl/instr_decoder.sv
rtl/flush_timer.sv
rtl/decode_control.sv
rtl/decode_stage.sv
rtl/dual_decode.sv
sim/dual_decode_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module dual_decode_tb -f dual_decode.f \
    -o dual_decode_sim &&
  ./obj_dir/dual_decode_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
  echo "run_sim: simulation ok" ||
  { echo "run_sim: simulation not ok"; exit 1; }

// File: sim/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

logic [31:0] lfsr_state;

// ****************************************
// galois lfsr stepped once per bit
// ****************************************
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0] == 1'b1) begin
    return (s >> 1) ^ 32'h80200003;
  end
  return s >> 1;
endfunction

function automatic logic [31:0] rand_bits(input int count);
  logic [31:0] value;
  int i;
  value = '0;
  for (i = 0; i < count; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    value = {value[30:0], lfsr_state[0]};
  end
  return value;
endfunction

// kind 0 to 10 picks lui auipc jal jalr branch load store op_imm op misc_mem system
function automatic logic [31:0] legal_instr(input int kind);
  logic [31:0] w;
  logic [2:0] f3;
  w = rand_bits(32);
  f3 = w[14:12];
  case (kind)
    0: w[6:0] = 7'h37;
    1: w[6:0] = 7'h17;
    2: w[6:0] = 7'h6f;
    3: w = {w[31:15], 3'b000, w[11:7], 7'h67};
    4: begin
      if (f3[2:1] == 2'b01) f3[2] = 1'b1;
      w = {w[31:15], f3, w[11:7], 7'h63};
    end
    5: begin
      if (f3 == 3'd3 || f3[2:1] == 2'b11) f3 = 3'd2;
      w = {w[31:15], f3, w[11:7], 7'h03};
    end
    6: begin
      f3 = (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]};
      w = {w[31:15], f3, w[11:7], 7'h23};
    end
    7: begin
      // shifts keep funct7 at base or the arithmetic variant
      if (f3 == 3'd1) w[31:25] = 7'h00;
      if (f3 == 3'd5) w[31:25] = {1'b0, w[30], 5'b00000};
      w[6:0] = 7'h13;
    end
    8: begin
      w[31:25] = (w[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      w[6:0] = 7'h33;
    end
    9: w = {w[31:15], 2'b00, f3[0], w[11:7], 7'h0f};
    default: w = w[20] ? 32'h00100073 : 32'h00000073;
  endcase
  return w;
endfunction

function automatic logic [31:0] illegal_instr();
  logic [31:0] w;
  logic [31:0] pick;
  w = rand_bits(32);
  pick = rand_bits(2);
  case (pick[1:0])
    2'd0: w[6:0] = 7'h0b;
    2'd1: w = {w[31:15], 3'd2, w[11:7], 7'h63};
    2'd2: w = {w[31:15], 3'd7, w[11:7], 7'h03};
    default: w = {w[31:15], 3'd5, w[11:7], 7'h23};
  endcase
  return w;
endfunction

// ****************************************
// reference decode from the rv32i rules
// ****************************************
function automatic decode_pkg::decoded_instr_t reference_decode(
  input logic [31:0] w,
  input logic [31:0] pc
);
  decode_pkg::decoded_instr_t d;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [31:0] imm_i;
  logic bad;
  f3 = w[14:12];
  f7 = w[31:25];
  imm_i = {{20{w[31]}}, w[31:20]};
  d = '0;
  d.pc = pc;
  d.rd = w[11:7];
  d.rs1 = w[19:15];
  d.rs2 = w[24:20];
  d.funct3 = f3;
  bad = 1'b0;
  case (w[6:0])
    7'h37, 7'h17: begin
      d.imm = {w[31:12], 12'h000};
      d.unit = decode_pkg::UNIT_ALU;
      d.wren = 1'b1;
    end
    7'h6f: begin
      d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      d.unit = decode_pkg::UNIT_BRANCH;
      d.wren = 1'b1;
    end
    7'h67: begin
      d.imm = imm_i;
      d.unit = decode_pkg::UNIT_BRANCH;
      d.wren = 1'b1;
      d.rden1 = 1'b1;
      bad = (f3 != 3'd0);
    end
    7'h63: begin
      d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      d.unit = decode_pkg::UNIT_BRANCH;
      d.rden1 = 1'b1;
      d.rden2 = 1'b1;
      bad = (f3 == 3'd2 || f3 == 3'd3);
    end
    7'h03: begin
      d.imm = imm_i;
      d.unit = decode_pkg::UNIT_LOAD;
      d.wren = 1'b1;
      d.rden1 = 1'b1;
      bad = (f3 == 3'd3 || f3 >= 3'd6);
    end
    7'h23: begin
      d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      d.unit = decode_pkg::UNIT_STORE;
      d.rden1 = 1'b1;
      d.rden2 = 1'b1;
      bad = (f3 > 3'd2);
    end
    7'h13: begin
      d.imm = imm_i;
      d.unit = decode_pkg::UNIT_ALU;
      d.wren = 1'b1;
      d.rden1 = 1'b1;
      bad = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
    end
    7'h33: begin
      d.unit = decode_pkg::UNIT_ALU;
      d.wren = 1'b1;
      d.rden1 = 1'b1;
      d.rden2 = 1'b1;
      bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
    end
    7'h0f: begin
      d.imm = imm_i;
      d.unit = decode_pkg::UNIT_SYSTEM;
      bad = (f3 > 3'd1);
    end
    7'h73: begin
      d.imm = imm_i;
      d.unit = decode_pkg::UNIT_SYSTEM;
      bad = (w != 32'h00000073) && (w != 32'h00100073);
    end
    default: bad = 1'b1;
  endcase
  if (bad == 1'b1) begin
    d.unit = decode_pkg::UNIT_NONE;
    d.wren = 1'b0;
    d.rden1 = 1'b0;
    d.rden2 = 1'b0;
  end
  d.exception = bad;
  d.valid = !bad;
  return d;
endfunction

function automatic decode_pkg::decode_pair_t reference_pair(
  input logic [31:0] pc,
  input logic [63:0] data,
  input logic taken,
  input logic [31:0] target
);
  decode_pkg::decode_pair_t p;
  p.slot0 = reference_decode(data[31:0], pc);
  p.slot1 = reference_decode(data[63:32], pc + 32'd4);
  p.pred_taken = taken;
  p.pred_target = target;
  return p;
endfunction

`endif

// File: sim/dual_decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dual_decode_tb;

  localparam int FLUSH_CYCLES = 3;
  localparam int TIMEOUT_CYCLES = 40;

  logic clock;
  logic reset;
  logic fetch_valid;
  logic fetch_ready;
  logic [31:0] fetch_pc;
  logic [decode_pkg::BUNDLE_WIDTH-1:0] fetch_data;
  logic fetch_pred_taken;
  logic [31:0] fetch_pred_target;
  logic redirect;
  logic halt;
  logic out_valid;
  logic out_ready;
  decode_pkg::decode_pair_t out_pair;

  // expected state of the output register
  decode_pkg::decode_pair_t exp_pair;
  logic exp_valid;
  logic ready_s;
  logic run_q;
  logic halt_q;
  logic stall_q;
  int flush_left;
  int errors = 0;
  int errors_before;
  int tests_run;
  logic [31:0] next_pc;

  `include "decode_model.svh"

  dual_decode #(
    .FLUSH_CYCLES(FLUSH_CYCLES)
  ) dual_decode_inst (
    .clock(clock),
    .reset(reset),
    .fetch_valid(fetch_valid),
    .fetch_ready(fetch_ready),
    .fetch_pc(fetch_pc),
    .fetch_data(fetch_data),
    .fetch_pred_taken(fetch_pred_taken),
    .fetch_pred_target(fetch_pred_target),
    .redirect(redirect),
    .halt(halt),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_pair(out_pair)
  );

  always #20 clock = ~clock;

  // ready is stable from the drive point to the next rising edge
  always @(negedge clock) begin
    ready_s <= fetch_ready;
  end

  always @(posedge clock) begin
    if (reset == 1'b0) begin
      exp_valid <= 1'b0;
      run_q <= 1'b0;
      halt_q <= 1'b0;
      stall_q <= 1'b0;
      flush_left <= 0;
    end else begin
      run_q <= 1'b1;
      halt_q <= halt;
      stall_q <= exp_valid && !out_ready && !redirect;
      if (redirect == 1'b1) begin
        exp_valid <= 1'b0;
        flush_left <= FLUSH_CYCLES;
      end else begin
        if (flush_left != 0) flush_left <= flush_left - 1;
        if (fetch_valid && ready_s && flush_left == 0) begin
          exp_valid <= 1'b1;
          exp_pair <= reference_pair(fetch_pc, fetch_data, fetch_pred_taken, fetch_pred_target);
        end else if (out_ready == 1'b1) begin
          exp_valid <= 1'b0;
        end
      end
    end
  end

  // ****************************************
  // checks at the falling edge
  // ****************************************
  valid_matches: assert property (@(negedge clock) disable iff (!reset)
    out_valid == exp_valid)
    else begin
      errors++;
      $display("error out_valid expected %h actual %h", exp_valid, out_valid);
    end

  slot0_matches: assert property (@(negedge clock) disable iff (!reset)
    exp_valid |-> out_pair.slot0 == exp_pair.slot0)
    else begin
      errors++;
      $display("error out_pair.slot0 expected %h actual %h", exp_pair.slot0, out_pair.slot0);
    end

  slot1_matches: assert property (@(negedge clock) disable iff (!reset)
    exp_valid |-> out_pair.slot1 == exp_pair.slot1)
    else begin
      errors++;
      $display("error out_pair.slot1 expected %h actual %h", exp_pair.slot1, out_pair.slot1);
    end

  prediction_matches: assert property (@(negedge clock) disable iff (!reset)
    exp_valid |-> {out_pair.pred_taken, out_pair.pred_target} ==
                  {exp_pair.pred_taken, exp_pair.pred_target})
    else begin
      errors++;
      $display("error out_pair.pred expected %h actual %h",
               {exp_pair.pred_taken, exp_pair.pred_target},
               {out_pair.pred_taken, out_pair.pred_target});
    end

  idle_after_reset: assert property (@(negedge clock) disable iff (!reset)
    !run_q |-> !fetch_ready && !out_valid)
    else begin
      errors++;
      $display("fetch_ready or out_valid went high in the first cycle after reset");
    end

  stall_blocks_fetch: assert property (@(negedge clock) disable iff (!reset)
    (exp_valid && !out_ready && flush_left == 0) |-> !fetch_ready)
    else begin
      errors++;
      $display("error fetch_ready expected 0 actual %h", fetch_ready);
    end

  flush_accepts: assert property (@(negedge clock) disable iff (!reset)
    (flush_left != 0) |-> fetch_ready)
    else begin
      errors++;
      $display("error fetch_ready expected 1 actual %h", fetch_ready);
    end

  halt_blocks_fetch: assert property (@(negedge clock) disable iff (!reset)
    (halt_q && flush_left == 0) |-> !fetch_ready)
    else begin
      errors++;
      $display("error fetch_ready expected 0 actual %h", fetch_ready);
    end

  ready_when_free: assert property (@(negedge clock) disable iff (!reset)
    (run_q && !halt_q && flush_left == 0 && (!exp_valid || out_ready)) |-> fetch_ready)
    else begin
      errors++;
      $display("error fetch_ready expected 1 actual %h", fetch_ready);
    end

  hold_stable: assert property (@(negedge clock) disable iff (!reset)
    stall_q |-> $stable(out_pair))
    else begin
      errors++;
      $display("output pair changed while out_ready was low");
    end

  // ****************************************
  // stimulus helpers
  // ****************************************
  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic present_bundle(input logic [31:0] lo, input logic [31:0] hi);
    fetch_valid = 1'b1;
    fetch_pc = next_pc;
    fetch_data = {hi, lo};
    fetch_pred_taken = (rand_bits(1) != 32'd0);
    fetch_pred_target = rand_bits(32);
    next_pc = next_pc + 32'd8;
  endtask

  task automatic wait_accept(input string what);
    int waited;
    waited = 0;
    @(negedge clock);
    while (fetch_ready !== 1'b1) begin
      if (waited >= TIMEOUT_CYCLES) abort_on_timeout(what);
      waited++;
      @(negedge clock);
    end
    next_cycle();
    fetch_valid = 1'b0;
  endtask

  task automatic send_bundle(input logic [31:0] lo, input logic [31:0] hi);
    present_bundle(lo, hi);
    wait_accept("fetch_ready on a bundle");
  endtask

  task automatic drain_output();
    int waited;
    waited = 0;
    out_ready = 1'b1;
    @(negedge clock);
    while (out_valid !== 1'b0) begin
      if (waited >= TIMEOUT_CYCLES) abort_on_timeout("the output register to drain");
      waited++;
      @(negedge clock);
    end
    next_cycle();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    errors_before = errors;
  endtask

  // ****************************************
  // tests
  // ****************************************
  task automatic random_legal_bundles();
    int i;
    for (i = 0; i < 33; i++) begin
      send_bundle(legal_instr(i % 11), legal_instr((i * 7 + 3) % 11));
    end
    drain_output();
    finish_test("random legal bundles");
  endtask

  task automatic slot_pairing();
    int i;
    for (i = 0; i < 8; i++) begin
      // first bundle sits at the top of the address space so pc plus 4 wraps
      next_pc = (i == 0) ? 32'hFFFF_FFFC : (rand_bits(32) & 32'hFFFF_FFFC);
      send_bundle(legal_instr(i), legal_instr(10 - i));
    end
    drain_output();
    finish_test("slot pairing");
  endtask

  task automatic illegal_slots();
    int i;
    for (i = 0; i < 12; i++) begin
      case (i % 3)
        0: send_bundle(illegal_instr(), legal_instr(i % 11));
        1: send_bundle(legal_instr(i % 11), illegal_instr());
        default: send_bundle(illegal_instr(), illegal_instr());
      endcase
    end
    drain_output();
    finish_test("illegal slots");
  endtask

  task automatic back_pressure();
    out_ready = 1'b0;
    send_bundle(legal_instr(4), legal_instr(5));
    present_bundle(legal_instr(6), legal_instr(7));
    repeat (5) next_cycle();
    out_ready = 1'b1;
    wait_accept("fetch_ready after back-pressure");
    drain_output();
    finish_test("back-pressure");
  endtask

  task automatic redirect_flush();
    int i;
    out_ready = 1'b0;
    send_bundle(legal_instr(0), legal_instr(1));
    redirect = 1'b1;
    next_cycle();
    redirect = 1'b0;
    out_ready = 1'b1;
    // three stale bundles are swallowed, the fourth gets through
    for (i = 0; i < FLUSH_CYCLES + 1; i++) begin
      send_bundle(legal_instr(i + 2), legal_instr(i + 6));
    end
    drain_output();
    finish_test("redirect");
  endtask

  task automatic halt_and_resume();
    halt = 1'b1;
    next_cycle();
    present_bundle(legal_instr(8), legal_instr(3));
    repeat (4) next_cycle();
    halt = 1'b0;
    wait_accept("fetch_ready after halt");
    drain_output();
    finish_test("halt");
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_data = '0;
    fetch_pred_taken = 1'b0;
    fetch_pred_target = '0;
    redirect = 1'b0;
    halt = 1'b0;
    out_ready = 1'b1;
    lfsr_state = 32'h761e;
    next_pc = 32'h0000_1000;
    errors_before = 0;
    tests_run = 0;
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b1;
    next_cycle();

    random_legal_bundles();
    slot_pairing();
    illegal_slots();
    back_pressure();
    redirect_flush();
    halt_and_resume();

    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/dual_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dual_decode #(
  parameter int FLUSH_CYCLES = 3
) (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  output logic fetch_ready,
  input logic [31:0] fetch_pc,
  input logic [decode_pkg::BUNDLE_WIDTH-1:0] fetch_data,
  input logic fetch_pred_taken,
  input logic [31:0] fetch_pred_target,
  input logic redirect,
  input logic halt,
  output logic out_valid,
  input logic out_ready,
  output decode_pkg::decode_pair_t out_pair
);

  logic accept_en;
  logic drop;
  logic clear;
  logic timer_start;
  logic timer_done;

  bundle_if fetch_if ();
  bundle_if out_if ();

  // ****************************************
  // plain ports onto the channels
  // ****************************************
  assign fetch_if.valid = fetch_valid;
  assign fetch_if.pc = fetch_pc;
  assign fetch_if.data = fetch_data;
  assign fetch_if.pred_taken = fetch_pred_taken;
  assign fetch_if.pred_target = fetch_pred_target;
  assign fetch_ready = fetch_if.ready;

  assign out_if.ready = out_ready;
  assign out_valid = out_if.valid;
  assign out_pair = out_if.pair;

  decode_stage decode_stage_inst (
    .clock(clock),
    .reset(reset),
    .fetch(fetch_if.fetch_side),
    .out(out_if.decode_side),
    .accept_en(accept_en),
    .drop(drop),
    .clear(clear)
  );

  decode_control decode_control_inst (
    .clock(clock),
    .reset(reset),
    .redirect(redirect),
    .halt(halt),
    .timer_done(timer_done),
    .accept_en(accept_en),
    .drop(drop),
    .clear(clear),
    .timer_start(timer_start)
  );

  flush_timer #(
    .FLUSH_CYCLES(FLUSH_CYCLES)
  ) flush_timer_inst (
    .clock(clock),
    .reset(reset),
    .start(timer_start),
    .done(timer_done)
  );

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input logic clock,
  input logic reset,
  bundle_if.fetch_side fetch,
  bundle_if.decode_side out,
  input logic accept_en,
  input logic drop,
  input logic clear
);

  localparam int SW = decode_pkg::SLOT_WIDTH;

  rv_isa_pkg::rv_instr_u instr_lo;
  rv_isa_pkg::rv_instr_u instr_hi;
  logic [31:0] pc_hi;
  decode_pkg::decoded_instr_t slot0;
  decode_pkg::decoded_instr_t slot1;
  decode_pkg::decode_pair_t pair_next;
  decode_pkg::decode_pair_t pair_r;
  logic valid_r;
  logic room;
  logic load;

  // ****************************************
  // bundle split and decode
  // ****************************************
  assign instr_lo = fetch.data[SW-1:0];
  assign instr_hi = fetch.data[decode_pkg::BUNDLE_WIDTH-1:SW];
  assign pc_hi = fetch.pc + 32'd4;

  instr_decoder slot0_decoder (
    .instr(instr_lo),
    .pc(fetch.pc),
    .slot(slot0)
  );

  instr_decoder slot1_decoder (
    .instr(instr_hi),
    .pc(pc_hi),
    .slot(slot1)
  );

  always_comb begin
    pair_next.slot0 = slot0;
    pair_next.slot1 = slot1;
    pair_next.pred_taken = fetch.pred_taken;
    pair_next.pred_target = fetch.pred_target;
  end

  // ****************************************
  // handshake and output register
  // ****************************************
  // register is free when empty or being drained this cycle
  assign room = !valid_r || out.ready;

  // during a flush every offered bundle is swallowed
  assign fetch.ready = drop || (accept_en && room);
  assign load = fetch.valid && accept_en && room;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      valid_r <= 1'b0;
    end else if (clear == 1'b1) begin
      valid_r <= 1'b0;
    end else if (load == 1'b1) begin
      valid_r <= 1'b1;
    end else if (out.ready == 1'b1) begin
      valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (clear == 1'b1) begin
      pair_r <= decode_pkg::init_pair;
    end else if (load == 1'b1) begin
      pair_r <= pair_next;
    end
  end

  assign out.valid = valid_r;
  assign out.pair = pair_r;

endmodule

`default_nettype wire

// File: rtl/decode_control.sv
`timescale 1ns/1ps
`default_nettype none

module decode_control (
  input logic clock,
  input logic reset,
  input logic redirect,
  input logic halt,
  input logic timer_done,
  output logic accept_en,
  output logic drop,
  output logic clear,
  output logic timer_start
);

  typedef enum logic [1:0] {
    RESET_WAIT,
    RUN,
    FLUSH,
    HALTED
  } state_e;

  state_e state;
  state_e state_next;

  always_comb begin
    state_next = state;
    case (state)
      RESET_WAIT: state_next = RUN;
      RUN: begin
        if (halt == 1'b1) begin
          state_next = HALTED;
        end
      end
      FLUSH: begin
        if (timer_done == 1'b1) begin
          state_next = halt ? HALTED : RUN;
        end
      end
      HALTED: begin
        if (halt == 1'b0) begin
          state_next = RUN;
        end
      end
      default: state_next = RESET_WAIT;
    endcase
    // redirect wins over halt and restarts a flush already running
    if (redirect == 1'b1) begin
      state_next = FLUSH;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state <= RESET_WAIT;
    end else begin
      state <= state_next;
    end
  end

  assign accept_en = (state == RUN);
  assign drop = (state == FLUSH);
  assign clear = redirect;
  assign timer_start = redirect;

endmodule

`default_nettype wire

// File: rtl/flush_timer.sv
`timescale 1ns/1ps
`default_nettype none

module flush_timer #(
  parameter int FLUSH_CYCLES = 3
) (
  input logic clock,
  input logic reset,
  input logic start,
  output logic done
);

  logic [3:0] count;

  // loaded one short so done is seen in the last flush cycle
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      count <= 4'd0;
    end else if (start == 1'b1) begin
      count <= 4'(FLUSH_CYCLES - 1);
    end else if (count != 4'd0) begin
      count <= count - 4'd1;
    end
  end

  assign done = (count == 4'd0);

endmodule

`default_nettype wire

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input rv_isa_pkg::rv_instr_u instr,
  input logic [31:0] pc,
  output decode_pkg::decoded_instr_t slot
);

  logic illegal;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign funct3 = instr.r_type.funct3;
  assign funct7 = instr.r_type.funct7;

  // ****************************************
  // immediates, one per format
  // ****************************************
  assign imm_i = {{20{instr.i_type.imm_11_0[11]}}, instr.i_type.imm_11_0};
  assign imm_s = {{20{instr.s_type.imm_11_5[6]}}, instr.s_type.imm_11_5,
                  instr.s_type.imm_4_0};
  assign imm_b = {{19{instr.b_type.imm_12}}, instr.b_type.imm_12, instr.b_type.imm_11,
                  instr.b_type.imm_10_5, instr.b_type.imm_4_1, 1'b0};
  assign imm_u = {instr.u_type.imm_31_12, 12'd0};
  assign imm_j = {{11{instr.j_type.imm_20}}, instr.j_type.imm_20, instr.j_type.imm_19_12,
                  instr.j_type.imm_11, instr.j_type.imm_10_1, 1'b0};

  always_comb begin
    slot = decode_pkg::init_instruction;
    slot.pc = pc;
    slot.rd = instr.r_type.rd;
    slot.rs1 = instr.r_type.rs1;
    slot.rs2 = instr.r_type.rs2;
    slot.funct3 = funct3;
    illegal = 1'b0;

    case (instr.r_type.opcode)
      rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: begin
        slot.imm = imm_u;
        slot.unit = decode_pkg::UNIT_ALU;
        slot.wren = 1'b1;
      end
      rv_isa_pkg::JAL: begin
        slot.imm = imm_j;
        slot.unit = decode_pkg::UNIT_BRANCH;
        slot.wren = 1'b1;
      end
      rv_isa_pkg::JALR: begin
        slot.imm = imm_i;
        slot.unit = decode_pkg::UNIT_BRANCH;
        slot.wren = 1'b1;
        slot.rden1 = 1'b1;
        illegal = (funct3 != 3'b000);
      end
      rv_isa_pkg::BRANCH: begin
        slot.imm = imm_b;
        slot.unit = decode_pkg::UNIT_BRANCH;
        slot.rden1 = 1'b1;
        slot.rden2 = 1'b1;
        illegal = !(funct3 inside {rv_isa_pkg::F3_BEQ, rv_isa_pkg::F3_BNE,
                                   rv_isa_pkg::F3_BLT, rv_isa_pkg::F3_BGE,
                                   rv_isa_pkg::F3_BLTU, rv_isa_pkg::F3_BGEU});
      end
      rv_isa_pkg::LOAD: begin
        slot.imm = imm_i;
        slot.unit = decode_pkg::UNIT_LOAD;
        slot.wren = 1'b1;
        slot.rden1 = 1'b1;
        illegal = !(funct3 inside {rv_isa_pkg::F3_LB, rv_isa_pkg::F3_LH, rv_isa_pkg::F3_LW,
                                   rv_isa_pkg::F3_LBU, rv_isa_pkg::F3_LHU});
      end
      rv_isa_pkg::STORE: begin
        slot.imm = imm_s;
        slot.unit = decode_pkg::UNIT_STORE;
        slot.rden1 = 1'b1;
        slot.rden2 = 1'b1;
        illegal = !(funct3 inside {rv_isa_pkg::F3_SB, rv_isa_pkg::F3_SH, rv_isa_pkg::F3_SW});
      end
      rv_isa_pkg::OP_IMM: begin
        slot.imm = imm_i;
        slot.unit = decode_pkg::UNIT_ALU;
        slot.wren = 1'b1;
        slot.rden1 = 1'b1;
        // shift amounts borrow the upper immediate bits as funct7
        if (funct3 == rv_isa_pkg::F3_SLL) begin
          illegal = (funct7 != rv_isa_pkg::F7_BASE);
        end else if (funct3 == rv_isa_pkg::F3_SRL_SRA) begin
          illegal = !(funct7 inside {rv_isa_pkg::F7_BASE, rv_isa_pkg::F7_ALT});
        end
      end
      rv_isa_pkg::OP: begin
        slot.unit = decode_pkg::UNIT_ALU;
        slot.wren = 1'b1;
        slot.rden1 = 1'b1;
        slot.rden2 = 1'b1;
        if (funct7 == rv_isa_pkg::F7_ALT) begin
          illegal = !(funct3 inside {rv_isa_pkg::F3_ADD_SUB, rv_isa_pkg::F3_SRL_SRA});
        end else begin
          illegal = (funct7 != rv_isa_pkg::F7_BASE);
        end
      end
      rv_isa_pkg::MISC_MEM: begin
        slot.imm = imm_i;
        slot.unit = decode_pkg::UNIT_SYSTEM;
        illegal = !(funct3 inside {rv_isa_pkg::F3_FENCE, rv_isa_pkg::F3_FENCE_I});
      end
      rv_isa_pkg::SYSTEM: begin
        slot.imm = imm_i;
        slot.unit = decode_pkg::UNIT_SYSTEM;
        illegal = (instr != rv_isa_pkg::ECALL_WORD) && (instr != rv_isa_pkg::EBREAK_WORD);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    // an illegal slot must not touch the register file
    if (illegal == 1'b1) begin
      slot.unit = decode_pkg::UNIT_NONE;
      slot.wren = 1'b0;
      slot.rden1 = 1'b0;
      slot.rden2 = 1'b0;
    end
    slot.exception = illegal;
    slot.valid = !illegal;
  end

endmodule

`default_nettype wire

// File: rtl/bundle_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bundle_if;

  logic valid;
  logic ready;
  logic [31:0] pc;
  logic [decode_pkg::BUNDLE_WIDTH-1:0] data;
  logic pred_taken;
  logic [31:0] pred_target;
  decode_pkg::decode_pair_t pair;

  // fetch channel as the stage sees it
  modport fetch_side (
    input valid,
    input pc,
    input data,
    input pred_taken,
    input pred_target,
    output ready
  );

  // decoded pair leaving the stage
  modport decode_side (
    output valid,
    output pair,
    input ready
  );

endinterface

`default_nettype wire

// File: rtl/decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int BUNDLE_WIDTH = 64;
  localparam int SLOT_WIDTH = 32;
  localparam logic [31:0] INIT_PC = 32'hFFFFFFFF;

  typedef enum logic [2:0] {
    UNIT_NONE   = 3'd0,
    UNIT_ALU    = 3'd1,
    UNIT_BRANCH = 3'd2,
    UNIT_LOAD   = 3'd3,
    UNIT_STORE  = 3'd4,
    UNIT_SYSTEM = 3'd5
  } unit_e;

  // one decoded slot
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [31:0] imm;
    unit_e unit;
    logic [2:0] funct3;
    logic wren;
    logic rden1;
    logic rden2;
    logic valid;
    logic exception;
  } decoded_instr_t;

  typedef struct packed {
    decoded_instr_t slot0;
    decoded_instr_t slot1;
    logic pred_taken;
    logic [31:0] pred_target;
  } decode_pair_t;

  // ****************************************
  // cleared values
  // ****************************************
  localparam decoded_instr_t init_instruction = '{
    pc: INIT_PC,
    rd: 5'd0,
    rs1: 5'd0,
    rs2: 5'd0,
    imm: 32'd0,
    unit: UNIT_NONE,
    funct3: 3'd0,
    wren: 1'b0,
    rden1: 1'b0,
    rden2: 1'b0,
    valid: 1'b0,
    exception: 1'b0
  };

  localparam decode_pair_t init_pair = '{
    slot0: init_instruction,
    slot1: init_instruction,
    pred_taken: 1'b0,
    pred_target: 32'd0
  };

endpackage

`default_nettype wire

// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // ****************************************
  // major opcodes
  // ****************************************
  typedef enum logic [6:0] {
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    OP_IMM   = 7'b0010011,
    OP       = 7'b0110011,
    MISC_MEM = 7'b0001111,
    SYSTEM   = 7'b1110011
  } rv_opcode_e;

  // branch conditions
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load and store widths
  localparam logic [2:0] F3_LB = 3'b000;
  localparam logic [2:0] F3_LH = 3'b001;
  localparam logic [2:0] F3_LW = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;
  localparam logic [2:0] F3_SB = 3'b000;
  localparam logic [2:0] F3_SH = 3'b001;
  localparam logic [2:0] F3_SW = 3'b010;

  // alu codes that constrain funct7
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;

  localparam logic [2:0] F3_FENCE = 3'b000;
  localparam logic [2:0] F3_FENCE_I = 3'b001;
  localparam logic [31:0] ECALL_WORD = 32'h00000073;
  localparam logic [31:0] EBREAK_WORD = 32'h00100073;

  // ****************************************
  // instruction formats
  // ****************************************
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } u_type_t;

  typedef struct packed {
    logic imm_20;
    logic [9:0] imm_10_1;
    logic imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    s_type_t s_type;
    b_type_t b_type;
    u_type_t u_type;
    j_type_t j_type;
  } rv_instr_u;

endpackage

`default_nettype wire
